// ==== logic/addr_pkg.sv ====
// sizes, page numbers and the address word union shared by the
// per-thread address translator
`default_nettype none

package addr_pkg;

    // read address and its page/index split
    localparam int ADDR_W  = 16;
    localparam int PAGE_W  = 4;
    localparam int INDEX_W = 12;

    // barrel scheduler threads
    localparam int THREAD_COUNT = 8;
    localparam int THREAD_W     = 3;

    // offsets are added modulo 2^OFFSET_W
    localparam int OFFSET_W = 16;

    // pages that are never translated
    // they are distinct, so at most one of them can match a given address
    localparam logic [PAGE_W-1:0] HIGHMEM_PAGE = 4'd14;
    localparam logic [PAGE_W-1:0] IO_PAGE      = 4'd15;

    // one address word, read flat for the offset add
    // or split into page and index for range decoding
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [PAGE_W-1:0]  page;  // upper bits select the page
            logic [INDEX_W-1:0] index;
        } fields;
    } addr_word_u;

endpackage

`default_nettype wire

// ==== logic/addr_stage_if.sv ====
// stage-1 address slot between the lookup/decode parts and the selector
`timescale 1ns/1ps
`default_nettype none

interface addr_stage_if;
    import addr_pkg::*;

    addr_word_u          raw_addr;  // address as sampled
    logic                bypass;    // address lies in high-mem or I/O page
    logic [OFFSET_W-1:0] offset;    // offset of the thread that owns the slot
    logic [THREAD_W-1:0] thread;

    modport lookup_mp (
        output offset,
        output thread
    );

    modport decode_mp (
        output raw_addr,
        output bypass
    );

    modport select_mp (
        input raw_addr,
        input bypass,
        input offset,
        input thread
    );

endinterface

`default_nettype wire

// ==== logic/offset_lookup.sv ====
// thread counter, per-thread offset table with its Wishbone classic slave,
// and the registered offset read for the current thread
`timescale 1ns/1ps
`default_nettype none

module offset_lookup (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [addr_pkg::THREAD_W-1:0] wb_adr,
    input  logic [addr_pkg::OFFSET_W-1:0] wb_dat_w,
    output logic [addr_pkg::OFFSET_W-1:0] wb_dat_r,
    output logic                          wb_ack,
    addr_stage_if.lookup_mp               stage
);
    import addr_pkg::*;

    logic [THREAD_W-1:0] thread_count;
    logic [OFFSET_W-1:0] offset_table [THREAD_COUNT];
    logic                wb_access;

    // a new access starts only while ack is low, so each strobe is served once
    assign wb_access = wb_cyc & wb_stb & ~wb_ack;

    // round robin over the hardware threads, one per clock
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            thread_count <= '0;
        end else if (thread_count == THREAD_W'(THREAD_COUNT - 1)) begin
            thread_count <= '0;
        end else begin
            thread_count <= thread_count + 1'b1;
        end
    end

    // table update lands on the ack edge
    // the next lookup already sees the new value
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
            for (int i = 0; i < THREAD_COUNT; i++) begin
                offset_table[i] <= '0;
            end
        end else begin
            wb_ack <= wb_access;
            if (wb_access && wb_we) begin
                offset_table[wb_adr] <= wb_dat_w;
            end
        end
    end

    // read data is valid while ack is high
    always_ff @(posedge clock) begin
        if (wb_access) begin
            wb_dat_r <= offset_table[wb_adr];
        end
    end

    // the thread number travels with its offset so the slot stays coherent
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            stage.offset <= '0;
            stage.thread <= '0;
        end else begin
            stage.offset <= offset_table[thread_count];
            stage.thread <= thread_count;
        end
    end

endmodule

`default_nettype wire

// ==== logic/range_decoder.sv ====
// page range check that marks high-mem and I/O addresses as untranslated
`timescale 1ns/1ps
`default_nettype none

module range_decoder (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic [addr_pkg::ADDR_W-1:0] addr_in,
    addr_stage_if.decode_mp             stage
);
    import addr_pkg::*;

    addr_word_u addr_view;
    logic       in_highmem;
    logic       in_io;

    assign addr_view  = addr_in;
    assign in_highmem = (addr_view.fields.page == HIGHMEM_PAGE);
    assign in_io      = (addr_view.fields.page == IO_PAGE);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            stage.raw_addr <= '0;
            stage.bypass   <= 1'b0;
        end else begin
            stage.raw_addr <= addr_view;
            stage.bypass   <= in_highmem | in_io;  // pages never overlap
        end
    end

endmodule

`default_nettype wire

// ==== logic/addr_select.sv ====
// final stage that picks the raw or offset address and tags it with its thread
`timescale 1ns/1ps
`default_nettype none

module addr_select (
    input  logic                          clock,
    input  logic                          arst_n,
    addr_stage_if.select_mp               stage,
    output logic [addr_pkg::ADDR_W-1:0]   addr_out,
    output logic [addr_pkg::THREAD_W-1:0] thread_out
);
    import addr_pkg::*;

    logic [ADDR_W-1:0] offset_addr;

    // wraps modulo 2^16, carry out is dropped
    assign offset_addr = stage.raw_addr.flat + stage.offset;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            addr_out   <= '0;
            thread_out <= '0;
        end else begin
            addr_out   <= stage.bypass ? stage.raw_addr.flat : offset_addr;
            thread_out <= stage.thread;
        end
    end

endmodule

`default_nettype wire

// ==== logic/addr_translate_top.sv ====
// top level of the per-thread address translator
// lookup and decode run side by side and feed the selector through one slot
`timescale 1ns/1ps
`default_nettype none

module addr_translate_top (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic [addr_pkg::ADDR_W-1:0]   addr_in,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [addr_pkg::THREAD_W-1:0] wb_adr,
    input  logic [addr_pkg::OFFSET_W-1:0] wb_dat_w,
    output logic [addr_pkg::OFFSET_W-1:0] wb_dat_r,
    output logic                          wb_ack,
    output logic [addr_pkg::ADDR_W-1:0]   addr_out,
    output logic [addr_pkg::THREAD_W-1:0] thread_out
);

    addr_stage_if stage_if ();

    offset_lookup offset_lookup_inst (
        .clock    (clock),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .stage    (stage_if.lookup_mp)
    );

    range_decoder range_decoder_inst (
        .clock   (clock),
        .arst_n  (arst_n),
        .addr_in (addr_in),
        .stage   (stage_if.decode_mp)
    );

    // two cycles from addr_in to addr_out in total
    addr_select addr_select_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .stage      (stage_if.select_mp),
        .addr_out   (addr_out),
        .thread_out (thread_out)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
// clock and reset source for the translator testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;  // 40 ns period
    end

    // reset spans two rising edges and drops just after the second
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/addr_translate_assert.sv ====
// concurrent checks on the Wishbone ack and on the thread tag sequence
`timescale 1ns/1ps
`default_nettype none

module addr_translate_assert (
    input logic                          clock,
    input logic                          arst_n,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic                          wb_ack,
    input logic [addr_pkg::THREAD_W-1:0] thread_out
);
    import addr_pkg::*;

    logic [1:0] warm_count;  // thread_out follows the counter once the pipeline is full
    int         ack_fails    = 0;
    int         start_fails  = 0;
    int         thread_fails = 0;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            warm_count <= '0;
        end else if (warm_count != 2'd3) begin
            warm_count <= warm_count + 2'd1;
        end
    end

    ack_one_cycle: assert property (@(posedge clock) disable iff (!arst_n)
        wb_ack |=> !wb_ack)
        else begin
            ack_fails++;
            $error("wb_ack high for two cycles in a row");
        end

    // every ack answers a strobe seen on the edge before
    ack_has_strobe: assert property (@(posedge clock) disable iff (!arst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            start_fails++;
            $error("wb_ack raised without cyc and stb on the previous cycle");
        end

    thread_steps: assert property (@(posedge clock) disable iff (!arst_n)
        (warm_count == 2'd3) |-> (thread_out == THREAD_W'($past(thread_out) + 1'b1)))
        else begin
            thread_fails++;
            $error("thread_out did not advance by one");
        end

endmodule

`default_nettype wire

// ==== dv/addr_translate_tb.sv ====
// testbench for the per-thread address translator with a shadow offset table,
// reference model, stream comparison, Wishbone checks, timeout and report
`timescale 1ns/1ps
`default_nettype none

module addr_translate_tb;
    import addr_pkg::*;

    logic                clock;
    logic                arst_n;
    logic [ADDR_W-1:0]   addr_in  = '0;
    logic                wb_cyc   = 1'b0;
    logic                wb_stb   = 1'b0;
    logic                wb_we    = 1'b0;
    logic [THREAD_W-1:0] wb_adr   = '0;
    logic [OFFSET_W-1:0] wb_dat_w = '0;
    logic [OFFSET_W-1:0] wb_dat_r;
    logic                wb_ack;
    logic [ADDR_W-1:0]   addr_out;
    logic [THREAD_W-1:0] thread_out;

    integer              seed = 32'h1aba;
    logic [OFFSET_W-1:0] shadow_table [THREAD_COUNT];
    logic [THREAD_W-1:0] next_thread = '0;  // thread of the next sampling edge
    int                  addr_mode   = 0;   // 0 any page, 1 translated only, 2 pages 14/15
    logic                check_en    = 1'b0;
    int                  test_idx    = 0;
    string test_names [5] = '{"passthrough", "translate", "bypass_pages",
                              "wb_read_back", "live_rewrite"};
    int    test_lengths [5] = '{70, 95, 55, 40, 110};
    int    stream_checks [5];
    int    stream_errors [5];
    int    direct_checks [5];
    int    direct_errors [5];
    int    total_checks = 0;
    int    total_errors = 0;
    int    assert_fails = 0;
    int    cycle_count  = 0;
    int    cycle_limit  = 100;

    logic [ADDR_W-1:0]   exp_addr_q [$];
    logic [THREAD_W-1:0] exp_thread_q [$];
    int                  exp_test_q [$];
    logic [ADDR_W-1:0]   exp_a;
    logic [THREAD_W-1:0] exp_t;
    int                  exp_i;
    logic [OFFSET_W-1:0] read_data;
    logic [THREAD_W-1:0] target;

    tb_clock tb_clock_inst (
        .clock  (clock),
        .arst_n (arst_n)
    );

    addr_translate_top addr_translate_top_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .addr_in    (addr_in),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .addr_out   (addr_out),
        .thread_out (thread_out)
    );

    bind addr_translate_top addr_translate_assert assert_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_ack     (wb_ack),
        .thread_out (thread_out)
    );

    // pages 14 and 15 pass through, every other page gets the thread's offset
    function automatic logic [ADDR_W-1:0] expected_addr(input logic [ADDR_W-1:0] addr,
                                                       input logic [THREAD_W-1:0] thread);
        logic [PAGE_W-1:0] page;
        page = addr[ADDR_W-1:INDEX_W];
        if (page == HIGHMEM_PAGE || page == IO_PAGE) begin
            return addr;
        end
        return addr + shadow_table[thread];  // wraps at 16 bits
    endfunction

    function automatic logic [ADDR_W-1:0] shape_addr(input logic [31:0] r, input int mode);
        logic [PAGE_W-1:0] page;
        page = r[15:12];
        if (mode == 1 && page >= HIGHMEM_PAGE) begin
            page = page - 4'd8;
        end else if (mode == 2) begin
            page = r[12] ? HIGHMEM_PAGE : IO_PAGE;
        end
        return {page, r[INDEX_W-1:0]};
    endfunction

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic wait_for_ack();
        int waited;
        waited = 1;
        step(1);
        while (!wb_ack && waited < 4) begin
            step(1);
            waited++;
        end
        direct_checks[test_idx]++;
        if (!wb_ack) begin
            direct_errors[test_idx]++;
            $display("test %s: wishbone ack never arrived", test_names[test_idx]);
        end else if (waited != 1) begin
            direct_errors[test_idx]++;
            $display("test %s: wishbone ack took %0d cycles instead of one",
                     test_names[test_idx], waited);
        end
    endtask

    task automatic release_bus();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        step(1);
        direct_checks[test_idx]++;
        if (wb_ack) begin
            direct_errors[test_idx]++;
            $display("test %s: wishbone ack stayed high a second cycle", test_names[test_idx]);
        end
    endtask

    // the table changes on the ack edge, so the shadow copy follows just after it
    task automatic wb_write(input logic [THREAD_W-1:0] adr, input logic [OFFSET_W-1:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_for_ack();
        shadow_table[adr] = data;
        release_bus();
    endtask

    task automatic wb_read(input logic [THREAD_W-1:0] adr, output logic [OFFSET_W-1:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_for_ack();
        data = wb_dat_r;
        release_bus();
    endtask

    task automatic start_test(input int idx, input int mode);
        test_idx  = idx;
        addr_mode = mode;
        check_en  = 1'b1;
    endtask

    task automatic end_test();
        int n_checks;
        int n_errors;
        check_en = 1'b0;
        step(3);  // drain the addresses still in the pipeline
        n_checks = stream_checks[test_idx] + direct_checks[test_idx];
        n_errors = stream_errors[test_idx] + direct_errors[test_idx];
        total_checks += n_checks;
        total_errors += n_errors;
        $display("test %s finished: %0d checks, %0d errors",
                 test_names[test_idx], n_checks, n_errors);
    endtask

    task automatic check_reset_state();
        direct_checks[test_idx] += 3;
        if (addr_out !== '0) begin
            direct_errors[test_idx]++;
            $display("error %s: reset addr_out expected %h actual %h",
                     test_names[test_idx], 16'h0, addr_out);
        end
        if (thread_out !== '0) begin
            direct_errors[test_idx]++;
            $display("error %s: reset thread_out expected 0 actual %0d",
                     test_names[test_idx], thread_out);
        end
        if (wb_ack !== 1'b0) begin
            direct_errors[test_idx]++;
            $display("error %s: reset wb_ack expected 0 actual %b", test_names[test_idx], wb_ack);
        end
    endtask

    // one new address every clock, a little after the edge
    initial begin
        forever begin
            @(posedge clock);
            #1;
            addr_in = shape_addr($random(seed), addr_mode);
        end
    end

    // sample at the rising edge, compare two edges later where the outputs are stable
    initial begin
        forever begin
            @(posedge clock);
            if (arst_n) begin
                exp_addr_q.push_back(expected_addr(addr_in, next_thread));
                exp_thread_q.push_back(next_thread);
                exp_test_q.push_back(check_en ? test_idx : -1);
                next_thread = next_thread + 3'd1;
            end
            @(negedge clock);
            if (exp_test_q.size() == 2) begin
                exp_a = exp_addr_q.pop_front();
                exp_t = exp_thread_q.pop_front();
                exp_i = exp_test_q.pop_front();
                if (exp_i >= 0) begin
                    stream_checks[exp_i]++;
                    if (addr_out !== exp_a) begin
                        stream_errors[exp_i]++;
                        $display("error %s: addr_out expected %h actual %h",
                                 test_names[exp_i], exp_a, addr_out);
                    end
                    if (thread_out !== exp_t) begin
                        stream_errors[exp_i]++;
                        $display("error %s: thread_out expected %0d actual %0d",
                                 test_names[exp_i], exp_t, thread_out);
                    end
                end
            end
        end
    end

    initial begin
        for (int i = 0; i < 5; i++) begin
            cycle_limit += 2 * test_lengths[i];
        end
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run still busy after %0d cycles", cycle_count);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        for (int i = 0; i < THREAD_COUNT; i++) begin
            shadow_table[i] = '0;
        end
        @(posedge arst_n);

        start_test(0, 0);
        check_reset_state();
        step(64);
        end_test();

        start_test(1, 1);
        for (int k = 0; k < THREAD_COUNT; k++) begin
            wb_write(THREAD_W'(k), OFFSET_W'(32'h2468 * (k + 1)));
        end
        step(64);
        end_test();

        start_test(2, 2);
        step(48);
        end_test();

        start_test(3, 0);
        wb_write(3'd2, 16'hbeef);
        wb_write(3'd5, 16'h0ff1);
        for (int k = 0; k < THREAD_COUNT; k++) begin
            wb_read(THREAD_W'(k), read_data);
            direct_checks[test_idx]++;
            if (read_data !== shadow_table[k]) begin
                direct_errors[test_idx]++;
                $display("error %s: thread %0d offset expected %h actual %h",
                         test_names[test_idx], k, shadow_table[k], read_data);
            end
        end
        end_test();

        // ack edge lands on the rewritten thread itself or on the thread before it
        start_test(4, 1);
        for (int k = 0; k < THREAD_COUNT; k++) begin
            target = (k % 2 == 0) ? THREAD_W'(k) : THREAD_W'(k + 7);
            while (next_thread != target) begin
                step(1);
            end
            wb_write(THREAD_W'(k), OFFSET_W'(32'h1357 + 32'h0101 * k));
        end
        step(16);
        end_test();

        assert_fails = addr_translate_top_inst.assert_inst.ack_fails
                     + addr_translate_top_inst.assert_inst.start_fails
                     + addr_translate_top_inst.assert_inst.thread_fails;
        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 total_checks, total_errors, assert_fails);
        if (total_errors == 0 && assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/addr_pkg.sv
logic/addr_stage_if.sv
logic/offset_lookup.sv
logic/range_decoder.sv
logic/addr_select.sv
logic/addr_translate_top.sv
dv/tb_clock.sv
dv/addr_translate_assert.sv
dv/addr_translate_tb.sv

// ==== Makefile ====
# Verilator build and run of the address translator testbench
TOP = addr_translate_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" sim.log; then echo "simulation incomplete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
